//--- run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fifo_sram -f tb.f

out="$(./obj_dir/Vtb_fifo_sram)" || { echo "$out"; echo "simulation exited with an error"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
else
  exit 1
fi

//--- src/fifo_pkg.sv
package fifo_pkg;

  // storage geometry.
  localparam int fifo_depth = 32;
  localparam int addr_width = $clog2(fifo_depth);
  localparam int data_width = 8;
  localparam int err_count_width = 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [err_count_width-1:0] err_count_t;

  // saturation point of the error counter.
  localparam err_count_t err_count_max = '1;

  // controller states.
  typedef enum logic [1:0] {
    st_empty   = 2'b00,
    st_between = 2'b01,
    st_readout = 2'b10,
    st_full    = 2'b11
  } ctrl_state_t;

  // request decoded from {push, pop}.
  typedef enum logic [1:0] {
    cmd_idle     = 2'b00,
    cmd_pop      = 2'b01,
    cmd_push     = 2'b10,
    cmd_push_pop = 2'b11
  } fifo_cmd_t;

endpackage

//--- src/fifo_read_result.sv
module fifo_read_result (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rd_issue,
  input  logic                 error,
  input  fifo_pkg::data_t      q,
  output fifo_pkg::data_t      rdata,
  output logic                 rvalid,
  output fifo_pkg::err_count_t err_count
);

  // capture the word that sits on q during readout.
  always_ff @(posedge clk) begin
    if (rd_issue) begin
      rdata <= q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd_issue;
    end
  end

  // error count, stuck at the top once reached.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (error && (err_count != fifo_pkg::err_count_max)) begin
      err_count <= err_count + 1'b1;
    end
  end

  // a pop always costs two cycles, so results never come back to back.
  a_rvalid_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid |=> !rvalid
  );

endmodule

//--- src/fifo_sram_ctrl.sv
module fifo_sram_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            push,
  input  logic            pop,
  output logic            empty,
  output logic            almost_empty,
  output logic            full,
  output logic            almost_full,
  output logic            error,
  output logic            cen,
  output logic            wen,
  output logic            oen,
  output logic            rd_issue,
  output fifo_pkg::addr_t addr
);

  fifo_pkg::ctrl_state_t state;
  fifo_pkg::ctrl_state_t state_next;
  fifo_pkg::fifo_cmd_t   cmd;
  fifo_pkg::addr_t       head;
  fifo_pkg::addr_t       head_next;
  fifo_pkg::addr_t       tail;
  fifo_pkg::addr_t       tail_next;
  logic                  head_inc;
  logic                  tail_inc;

  // two-bit request decode.
  always_comb begin
    case ({push, pop})
      2'b01:   cmd = fifo_pkg::cmd_pop;
      2'b10:   cmd = fifo_pkg::cmd_push;
      2'b11:   cmd = fifo_pkg::cmd_push_pop;
      default: cmd = fifo_pkg::cmd_idle;
    endcase
  end

  // pointers wrap at the last entry.
  always_comb begin
    if (!head_inc) begin
      head_next = head;
    end else if (head == fifo_pkg::addr_t'(fifo_pkg::fifo_depth - 1)) begin
      head_next = '0;
    end else begin
      head_next = head + 1'b1;
    end
    if (!tail_inc) begin
      tail_next = tail;
    end else if (tail == fifo_pkg::addr_t'(fifo_pkg::fifo_depth - 1)) begin
      tail_next = '0;
    end else begin
      tail_next = tail + 1'b1;
    end
  end

  // one word left, or one slot left.
  assign almost_empty = (tail == head - 1'b1);
  assign almost_full  = (head == tail - 1'b1);

  assign empty    = (state == fifo_pkg::st_empty);
  assign full     = (state == fifo_pkg::st_full);
  assign rd_issue = (state == fifo_pkg::st_readout);

  // memory stays selected with output enabled; wen picks write or read.
  assign cen = 1'b0;
  assign oen = 1'b0;

  always_comb begin
    state_next = state;
    head_inc   = 1'b0;
    tail_inc   = 1'b0;
    wen        = 1'b1;
    addr       = '0;
    error      = 1'b0;
    case (state)
      fifo_pkg::st_empty: begin
        if (cmd == fifo_pkg::cmd_push) begin
          addr       = head;
          wen        = 1'b0;
          head_inc   = 1'b1;
          state_next = fifo_pkg::st_between;
        end else if (cmd != fifo_pkg::cmd_idle) begin
          error = 1'b1;
        end
      end
      fifo_pkg::st_between: begin
        if (cmd == fifo_pkg::cmd_push) begin
          addr     = head;
          wen      = 1'b0;
          head_inc = 1'b1;
          if (almost_full) begin
            state_next = fifo_pkg::st_full;
          end
        end else if (cmd == fifo_pkg::cmd_pop) begin
          addr       = tail;
          state_next = fifo_pkg::st_readout;
        end else if (cmd == fifo_pkg::cmd_push_pop) begin
          error = 1'b1;
        end
      end
      fifo_pkg::st_readout: begin
        // word is on q now; retire it and refuse any request.
        tail_inc = 1'b1;
        error    = (cmd != fifo_pkg::cmd_idle);
        if (almost_empty) begin
          state_next = fifo_pkg::st_empty;
        end else begin
          state_next = fifo_pkg::st_between;
        end
      end
      fifo_pkg::st_full: begin
        if (cmd == fifo_pkg::cmd_pop) begin
          addr       = tail;
          state_next = fifo_pkg::st_readout;
        end else if (cmd != fifo_pkg::cmd_idle) begin
          error = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fifo_pkg::st_empty;
      head  <= '0;
      tail  <= '0;
    end else begin
      state <= state_next;
      head  <= head_next;
      tail  <= tail_next;
    end
  end

  // full memory and the readout cycle must never write.
  a_no_write_full_readout: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == fifo_pkg::st_full || state == fifo_pkg::st_readout) |-> wen
  );

  // a dropped request leaves the write pointer where it was.
  a_head_hold_on_error: assert property (
    @(posedge clk) disable iff (!rst_n)
    error |=> (head == $past(head))
  );

endmodule

//--- src/fifo_sram_top.sv
module fifo_sram_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  logic                 pop,
  input  fifo_pkg::data_t      wdata,
  output fifo_pkg::data_t      rdata,
  output logic                 rvalid,
  output logic                 empty,
  output logic                 almost_empty,
  output logic                 full,
  output logic                 almost_full,
  output logic                 error,
  output fifo_pkg::err_count_t err_count
);

  logic            cen;
  logic            wen;
  logic            oen;
  logic            rd_issue;
  fifo_pkg::addr_t addr;
  fifo_pkg::data_t q;

  fifo_sram_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .pop          (pop),
    .empty        (empty),
    .almost_empty (almost_empty),
    .full         (full),
    .almost_full  (almost_full),
    .error        (error),
    .cen          (cen),
    .wen          (wen),
    .oen          (oen),
    .rd_issue     (rd_issue),
    .addr         (addr)
  );

  sram_sp i_sram (
    .clk  (clk),
    .cen  (cen),
    .wen  (wen),
    .oen  (oen),
    .addr (addr),
    .d    (wdata),
    .q    (q)
  );

  fifo_read_result i_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_issue  (rd_issue),
    .error     (error),
    .q         (q),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .err_count (err_count)
  );

endmodule

//--- src/sram_sp.sv
module sram_sp (
  input  logic            clk,
  input  logic            cen,
  input  logic            wen,
  input  logic            oen,
  input  fifo_pkg::addr_t addr,
  input  fifo_pkg::data_t d,
  output fifo_pkg::data_t q
);

  fifo_pkg::data_t mem [fifo_pkg::fifo_depth];

  // write on cen and wen low.
  always_ff @(posedge clk) begin
    if (!cen && !wen) begin
      mem[addr] <= d;
    end
  end

  // registered read; q keeps its last word otherwise.
  always_ff @(posedge clk) begin
    if (!cen && wen && !oen) begin
      q <= mem[addr];
    end
  end

  a_addr_known: assert property (
    @(posedge clk) !cen |-> !$isunknown(addr)
  );

endmodule

//--- tb.f
src/fifo_pkg.sv
src/fifo_sram_ctrl.sv
src/sram_sp.sv
src/fifo_read_result.sv
src/fifo_sram_top.sv
tb/tb_fifo_sram.sv

//--- tb/tb_fifo_sram.sv
module tb_fifo_sram;

  localparam logic [1:0] op_idle     = 2'b00;
  localparam logic [1:0] op_pop      = 2'b01;
  localparam logic [1:0] op_push     = 2'b10;
  localparam logic [1:0] op_push_pop = 2'b11;

  typedef struct packed {
    logic [1:0]           op;
    fifo_pkg::data_t      data;
    logic                 exp_error;
    logic                 exp_empty;
    logic                 exp_almost_empty;
    logic                 exp_full;
    logic                 exp_almost_full;
    logic                 exp_rvalid;
    fifo_pkg::err_count_t exp_err_count;
  } entry_t;

  logic                 clk;
  logic                 rst_n;
  logic                 push;
  logic                 pop;
  fifo_pkg::data_t      wdata;
  fifo_pkg::data_t      rdata;
  logic                 rvalid;
  logic                 empty;
  logic                 almost_empty;
  logic                 full;
  logic                 almost_full;
  logic                 error;
  fifo_pkg::err_count_t err_count;

  entry_t          stim_q[$];
  fifo_pkg::data_t model_q[$];
  fifo_pkg::data_t exp_data_q[$];
  logic            stim_ready;
  integer          seed;
  int              checks;
  int              errors;

  // reference model of the FIFO, advanced once per table entry.
  int   m_occ;
  logic m_readout;
  logic m_rvalid_pending;
  int   m_err_total;

  fifo_sram_top i_fifo_sram_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .pop          (pop),
    .wdata        (wdata),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .empty        (empty),
    .almost_empty (almost_empty),
    .full         (full),
    .almost_full  (almost_full),
    .error        (error),
    .err_count    (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_data(input string name, input fifo_pkg::data_t exp,
                            input fifo_pkg::data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input fifo_pkg::err_count_t exp,
                             input fifo_pkg::err_count_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // runs one cycle of the model and appends the entry with its expected outputs.
  task automatic add_entry(input logic [1:0] op);
    entry_t e;
    logic   accept_push;
    logic   accept_pop;
    e.op               = op;
    e.data             = fifo_pkg::data_t'($random(seed));
    e.exp_empty        = !m_readout && (m_occ == 0);
    e.exp_full         = !m_readout && (m_occ == 32);
    e.exp_almost_empty = (m_occ == 1);
    e.exp_almost_full  = (m_occ == 31);
    e.exp_rvalid       = m_rvalid_pending;
    e.exp_err_count    = (m_err_total > 255) ? 8'd255 : fifo_pkg::err_count_t'(m_err_total);
    e.exp_error        = 1'b0;
    m_rvalid_pending   = 1'b0;
    accept_push        = 1'b0;
    accept_pop         = 1'b0;
    if (m_readout) begin
      // second cycle of a pop; the word leaves the FIFO here.
      e.exp_error      = (op != op_idle);
      m_readout        = 1'b0;
      m_occ            = m_occ - 1;
      m_rvalid_pending = 1'b1;
    end else if (op == op_push_pop) begin
      e.exp_error = 1'b1;
    end else if (op == op_push) begin
      if (m_occ == 32) begin
        e.exp_error = 1'b1;
      end else begin
        accept_push = 1'b1;
      end
    end else if (op == op_pop) begin
      if (m_occ == 0) begin
        e.exp_error = 1'b1;
      end else begin
        accept_pop = 1'b1;
      end
    end
    if (accept_push) begin
      model_q.push_back(e.data);
      m_occ = m_occ + 1;
    end
    if (accept_pop) begin
      exp_data_q.push_back(model_q.pop_front());
      m_readout = 1'b1;
    end
    if (e.exp_error) begin
      m_err_total = m_err_total + 1;
    end
    stim_q.push_back(e);
  endtask

  task automatic build_stimulus();
    integer     r;
    logic [3:0] sel;
    logic [1:0] op;
    repeat (2) add_entry(op_idle);
    add_entry(op_pop);
    add_entry(op_push_pop);
    // fill to full, then knock on the full FIFO.
    repeat (32) add_entry(op_push);
    add_entry(op_push);
    add_entry(op_push_pop);
    add_entry(op_idle);
    // drain, with a few requests landing in the readout cycle.
    while (m_occ > 0) begin
      add_entry(op_pop);
      if (m_occ % 5 == 0) begin
        add_entry(op_push);
      end else if (m_occ % 7 == 0) begin
        add_entry(op_pop);
      end else begin
        add_entry(op_idle);
      end
    end
    add_entry(op_pop);
    add_entry(op_push);
    add_entry(op_push);
    add_entry(op_push_pop);
    // random mix from here; pointers are already past the wrap point.
    repeat (240) begin
      r   = $random(seed);
      sel = r[3:0];
      if (sel < 4'd6) begin
        op = op_push;
      end else if (sel < 4'd12) begin
        op = op_pop;
      end else if (sel < 4'd14) begin
        op = op_push_pop;
      end else begin
        op = op_idle;
      end
      add_entry(op);
    end
    // enough illegal cycles to drive err_count into saturation.
    repeat (260) add_entry(op_push_pop);
    repeat (4) add_entry(op_idle);
  endtask

  initial begin
    wait (stim_ready === 1'b1);
    repeat (stim_q.size() * 3 + 50) @(posedge clk);
    $display("watchdog expired before the stimulus table was finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    entry_t               e;
    fifo_pkg::err_count_t exp_count;
    rst_n            = 1'b0;
    push             = 1'b0;
    pop              = 1'b0;
    wdata            = '0;
    stim_ready       = 1'b0;
    seed             = 29281;
    checks           = 0;
    errors           = 0;
    m_occ            = 0;
    m_readout        = 1'b0;
    m_rvalid_pending = 1'b0;
    m_err_total      = 0;
    build_stimulus();
    stim_ready = 1'b1;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset empty", 1'b1, empty);
    check_flag("reset full", 1'b0, full);
    check_flag("reset almost_full", 1'b0, almost_full);
    check_flag("reset almost_empty", 1'b0, almost_empty);
    check_flag("reset rvalid", 1'b0, rvalid);
    check_flag("reset error", 1'b0, error);
    check_count("reset err_count", '0, err_count);

    for (int i = 0; i < stim_q.size(); i++) begin
      e = stim_q[i];
      @(posedge clk);
      push  <= e.op[1];
      pop   <= e.op[0];
      wdata <= e.data;
      @(negedge clk);
      check_flag($sformatf("entry %0d error", i), e.exp_error, error);
      check_flag($sformatf("entry %0d empty", i), e.exp_empty, empty);
      check_flag($sformatf("entry %0d almost_empty", i), e.exp_almost_empty, almost_empty);
      check_flag($sformatf("entry %0d full", i), e.exp_full, full);
      check_flag($sformatf("entry %0d almost_full", i), e.exp_almost_full, almost_full);
      check_flag($sformatf("entry %0d rvalid", i), e.exp_rvalid, rvalid);
      check_count($sformatf("entry %0d err_count", i), e.exp_err_count, err_count);
      if (rvalid === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("entry %0d: rvalid is high but no word was left to read", i);
        end else begin
          check_data($sformatf("entry %0d rdata", i), exp_data_q.pop_front(), rdata);
        end
      end
    end

    if (exp_data_q.size() != 0) begin
      errors++;
      $display("%0d popped words never came out on rdata", exp_data_q.size());
    end
    exp_count = (m_err_total > 255) ? 8'd255 : fifo_pkg::err_count_t'(m_err_total);
    check_count("final err_count", exp_count, err_count);

    $display("checks run: %0d, checks failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
